// ==== mem_geom_pkg.sv ====
package mem_geom_pkg;

  // ####################
  // Array geometry
  // ####################

  // Data word width.
  localparam int word_w = 15;

  // Address width and the depth it spans.
  localparam int addr_w = 8;
  localparam int mem_depth = 1 << addr_w;

  // ####################
  // Geometry types
  // ####################

  // One data word, also used as a per-bit write mask.
  typedef logic [word_w-1:0] word_t;

  // One word address.
  typedef logic [addr_w-1:0] addr_t;

endpackage

// ==== mem_port_pkg.sv ====
package mem_port_pkg;

  import mem_geom_pkg::*;

  // ####################
  // Port counts
  // ####################
  localparam int num_rd = 2;
  localparam int num_wr = 3;

  // One strobe bit per port.
  typedef logic [num_rd-1:0] rd_strb_t;
  typedef logic [num_wr-1:0] wr_strb_t;

  // ####################
  // Packed port buses
  // ####################

  // Port 0 sits in the low bits of every bus.
  typedef logic [num_rd*addr_w-1:0] rd_addr_bus_t;
  typedef logic [num_wr*addr_w-1:0] wr_addr_bus_t;
  typedef logic [num_rd*word_w-1:0] rd_data_bus_t;

  // Write data and write mask share one layout.
  typedef logic [num_wr*word_w-1:0] wr_data_bus_t;

endpackage

// ==== mprt_3w2r_sram.sv ====
`timescale 1ns/1ns

module mprt_3w2r_sram
  import mem_geom_pkg::*;
#(
  parameter int T1_DELAY = 1
) (
  input  logic  clk,

  // Read ports.
  input  logic  t1_read_d,
  input  addr_t t1_addr_d,
  output word_t t1_dout_d,
  input  logic  t1_read_e,
  input  addr_t t1_addr_e,
  output word_t t1_dout_e,

  // Write ports, A lowest priority.
  input  logic  t1_write_a,
  input  addr_t t1_addr_a,
  input  word_t t1_din_a,
  input  word_t t1_bw_a,
  input  logic  t1_write_b,
  input  addr_t t1_addr_b,
  input  word_t t1_din_b,
  input  word_t t1_bw_b,
  input  logic  t1_write_c,
  input  addr_t t1_addr_c,
  input  word_t t1_din_c,
  input  word_t t1_bw_c
);

  localparam int rd_ports = 2;

  word_t mem [mem_depth];

  word_t merged_a;
  word_t merged_b;
  word_t merged_c;

  logic [rd_ports-1:0] rd_en;
  addr_t               rd_addr [rd_ports];
  word_t               rd_out  [rd_ports];

  // Masked bits take din, the rest keep the old word.
  function automatic word_t apply_mask(word_t old, word_t data, word_t mask);
    return (old & ~mask) | (data & mask);
  endfunction

  // Next value of one word with all same-cycle writes applied, A then B then C.
  function automatic word_t merge_at(addr_t addr);
    word_t w;
    w = mem[addr];
    if (t1_write_a && (t1_addr_a == addr)) begin
      w = apply_mask(w, t1_din_a, t1_bw_a);
    end
    if (t1_write_b && (t1_addr_b == addr)) begin
      w = apply_mask(w, t1_din_b, t1_bw_b);
    end
    if (t1_write_c && (t1_addr_c == addr)) begin
      w = apply_mask(w, t1_din_c, t1_bw_c);
    end
    return w;
  endfunction

  // ####################
  // Write path
  // ####################

  // Ports on one address compute the same merged word.
  always_comb begin
    merged_a = merge_at(t1_addr_a);
    merged_b = merge_at(t1_addr_b);
    merged_c = merge_at(t1_addr_c);
  end

  always_ff @(posedge clk) begin
    if (t1_write_a) begin
      mem[t1_addr_a] <= merged_a;
    end
    if (t1_write_b) begin
      mem[t1_addr_b] <= merged_b;
    end
    if (t1_write_c) begin
      mem[t1_addr_c] <= merged_c;
    end
  end

  // ####################
  // Read path
  // ####################
  assign rd_en      = {t1_read_e, t1_read_d};
  assign rd_addr[0] = t1_addr_d;
  assign rd_addr[1] = t1_addr_e;

  generate
    for (genvar p = 0; p < rd_ports; p++) begin : g_rd
      word_t stage [T1_DELAY];

      // First stage samples old contents and holds between reads.
      always_ff @(posedge clk) begin
        if (rd_en[p]) begin
          stage[0] <= mem[rd_addr[p]];
        end
        for (int i = 1; i < T1_DELAY; i++) begin
          stage[i] <= stage[i-1];
        end
      end

      assign rd_out[p] = stage[T1_DELAY-1];
    end
  endgenerate

  assign t1_dout_d = rd_out[0];
  assign t1_dout_e = rd_out[1];

endmodule

// ==== algo_2r3w_wrap.sv ====
`timescale 1ns/1ns

module algo_2r3w_wrap
  import mem_geom_pkg::*, mem_port_pkg::*;
#(
  parameter int T1_DELAY = 1,
  parameter int FLOPOUT  = 1
) (
  input  logic         clk,
  input  logic         rst,

  // Logical read ports.
  input  rd_strb_t     read,
  input  rd_addr_bus_t rd_adr,
  output rd_data_bus_t rd_dout,
  output rd_strb_t     rd_vld,

  // Logical write ports.
  input  wr_strb_t     write,
  input  wr_addr_bus_t wr_adr,
  input  wr_data_bus_t din,
  input  wr_data_bus_t bw,

  // Array read ports.
  output logic         t1_read_d,
  output addr_t        t1_addr_d,
  input  word_t        t1_dout_d,
  output logic         t1_read_e,
  output addr_t        t1_addr_e,
  input  word_t        t1_dout_e,

  // Array write ports.
  output logic         t1_write_a,
  output addr_t        t1_addr_a,
  output word_t        t1_din_a,
  output word_t        t1_bw_a,
  output logic         t1_write_b,
  output addr_t        t1_addr_b,
  output word_t        t1_din_b,
  output word_t        t1_bw_b,
  output logic         t1_write_c,
  output addr_t        t1_addr_c,
  output word_t        t1_din_c,
  output word_t        t1_bw_c
);

  // Valid must line up with array latency plus output flops.
  localparam int VLD_DEPTH = T1_DELAY + FLOPOUT;

  rd_data_bus_t rd_word;
  rd_strb_t     vld_pipe [VLD_DEPTH];

  // ####################
  // Read port mapping
  // ####################
  assign t1_read_d = read[0];
  assign t1_addr_d = rd_adr[0*addr_w +: addr_w];
  assign t1_read_e = read[1];
  assign t1_addr_e = rd_adr[1*addr_w +: addr_w];

  // Port D lands in the low word.
  assign rd_word = {t1_dout_e, t1_dout_d};

  // ####################
  // Write port mapping
  // ####################
  assign t1_write_a = write[0];
  assign t1_addr_a  = wr_adr[0*addr_w +: addr_w];
  assign t1_din_a   = din[0*word_w +: word_w];
  assign t1_bw_a    = bw[0*word_w +: word_w];

  assign t1_write_b = write[1];
  assign t1_addr_b  = wr_adr[1*addr_w +: addr_w];
  assign t1_din_b   = din[1*word_w +: word_w];
  assign t1_bw_b    = bw[1*word_w +: word_w];

  assign t1_write_c = write[2];
  assign t1_addr_c  = wr_adr[2*addr_w +: addr_w];
  assign t1_din_c   = din[2*word_w +: word_w];
  assign t1_bw_c    = bw[2*word_w +: word_w];

  // ####################
  // Read valid pipeline
  // ####################
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < VLD_DEPTH; i++) begin
        vld_pipe[i] <= '0;
      end
    end else begin
      vld_pipe[0] <= read;
      for (int i = 1; i < VLD_DEPTH; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  assign rd_vld = vld_pipe[VLD_DEPTH-1];

  // ####################
  // Read data pipeline
  // ####################
  generate
    if (FLOPOUT > 0) begin : g_flopout
      rd_data_bus_t dout_pipe [FLOPOUT];

      always_ff @(posedge clk) begin
        dout_pipe[0] <= rd_word;
        for (int i = 1; i < FLOPOUT; i++) begin
          dout_pipe[i] <= dout_pipe[i-1];
        end
      end

      assign rd_dout = dout_pipe[FLOPOUT-1];
    end else begin : g_direct
      assign rd_dout = rd_word;
    end
  endgenerate

endmodule

// ==== mem_2r3w_top.sv ====
`timescale 1ns/1ns

module mem_2r3w_top
  import mem_geom_pkg::*, mem_port_pkg::*;
#(
  parameter int T1_DELAY = 1,
  parameter int FLOPOUT  = 1
) (
  input  logic         clk,
  input  logic         rst,
  input  rd_strb_t     read,
  input  rd_addr_bus_t rd_adr,
  input  wr_strb_t     write,
  input  wr_addr_bus_t wr_adr,
  input  wr_data_bus_t din,
  input  wr_data_bus_t bw,
  output rd_data_bus_t rd_dout,
  output rd_strb_t     rd_vld
);

  // ####################
  // Array side wiring
  // ####################
  logic  t1_read_d;
  addr_t t1_addr_d;
  word_t t1_dout_d;
  logic  t1_read_e;
  addr_t t1_addr_e;
  word_t t1_dout_e;

  logic  t1_write_a;
  addr_t t1_addr_a;
  word_t t1_din_a;
  word_t t1_bw_a;
  logic  t1_write_b;
  addr_t t1_addr_b;
  word_t t1_din_b;
  word_t t1_bw_b;
  logic  t1_write_c;
  addr_t t1_addr_c;
  word_t t1_din_c;
  word_t t1_bw_c;

  algo_2r3w_wrap #(
    .T1_DELAY (T1_DELAY),
    .FLOPOUT  (FLOPOUT)
  ) u_wrap (
    .*
  );

  // Same read latency as the wrapper's valid pipeline.
  mprt_3w2r_sram #(
    .T1_DELAY (T1_DELAY)
  ) u_sram (
    .clk        (clk),
    .t1_read_d  (t1_read_d),
    .t1_addr_d  (t1_addr_d),
    .t1_dout_d  (t1_dout_d),
    .t1_read_e  (t1_read_e),
    .t1_addr_e  (t1_addr_e),
    .t1_dout_e  (t1_dout_e),
    .t1_write_a (t1_write_a),
    .t1_addr_a  (t1_addr_a),
    .t1_din_a   (t1_din_a),
    .t1_bw_a    (t1_bw_a),
    .t1_write_b (t1_write_b),
    .t1_addr_b  (t1_addr_b),
    .t1_din_b   (t1_din_b),
    .t1_bw_b    (t1_bw_b),
    .t1_write_c (t1_write_c),
    .t1_addr_c  (t1_addr_c),
    .t1_din_c   (t1_din_c),
    .t1_bw_c    (t1_bw_c)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period_ns  = 20,
  parameter int rst_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2);
      clk = ~clk;
    end
  end

  // Reset released on a falling edge.
  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== tb_mem_2r3w.sv ====
`timescale 1ns/1ns

module tb_mem_2r3w
  import mem_geom_pkg::*, mem_port_pkg::*;
();

  // Read strobe to rd_vld through the array and output flop.
  localparam int rd_latency = 2;

  logic         clk;
  logic         rst;
  rd_strb_t     read;
  rd_addr_bus_t rd_adr;
  wr_strb_t     write;
  wr_addr_bus_t wr_adr;
  wr_data_bus_t din;
  wr_data_bus_t bw;
  rd_data_bus_t rd_dout;
  rd_strb_t     rd_vld;

  // One entry per stimulus line.
  string        st_name [$];
  wr_strb_t     st_wr   [$];
  wr_addr_bus_t st_wadr [$];
  wr_data_bus_t st_din  [$];
  wr_data_bus_t st_bw   [$];
  rd_strb_t     st_rd   [$];
  rd_addr_bus_t st_radr [$];
  rd_data_bus_t st_exp  [$];

  // Expected words per read port in issue order.
  word_t exp_q  [num_rd][$];
  string exp_nm [num_rd][$];

  // Read strobes of the last cycles with the newest first.
  rd_strb_t rd_hist [rd_latency];
  string    nm_hist [rd_latency];

  integer seed = 32'haefa;
  bit     stim_loaded = 1'b0;
  int     wd_limit_ns;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  mem_2r3w_top DUT (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .rd_adr  (rd_adr),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld)
  );

  // ####################
  // Checks
  // ####################
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: rd_dout expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_vld(input string name, input rd_strb_t exp, input rd_strb_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: rd_vld expected %b, actual %b", name, exp, act));
    end
  endtask

  // Outputs of the cycle that just ended.
  task automatic check_outputs();
    compare_vld(nm_hist[rd_latency-1], rd_hist[rd_latency-1], rd_vld);
    for (int p = 0; p < num_rd; p++) begin
      if (rd_vld[p]) begin
        if (exp_q[p].size() == 0) begin
          abort_run($sformatf("Unexpected read valid seen on port %0d.", p));
        end else begin
          compare_word(exp_nm[p].pop_front(), exp_q[p].pop_front(),
                       rd_dout[p*word_w +: word_w]);
        end
      end
    end
  endtask

  // ####################
  // Stimulus
  // ####################
  task automatic load_stim();
    int       fd;
    int       n;
    string    line;
    string    nm;
    wr_strb_t w;
    addr_t    wa0, wa1, wa2;
    word_t    d0, d1, d2;
    word_t    m0, m1, m2;
    rd_strb_t r;
    addr_t    ra0, ra1;
    word_t    e0, e1;
    fd = $fopen("mem_2r3w_stim.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file mem_2r3w_stim.txt.");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %b %h %h %h %h %h %h %h %h %h %b %h %h %h %h",
                    nm, w, wa0, wa1, wa2, d0, d1, d2, m0, m1, m2, r, ra0, ra1, e0, e1);
        if (n != 16) begin
          abort_run($sformatf("Malformed stimulus line: %s", line));
        end else begin
          st_name.push_back(nm);
          st_wr.push_back(w);
          st_wadr.push_back({wa2, wa1, wa0});
          st_din.push_back({d2, d1, d0});
          st_bw.push_back({m2, m1, m0});
          st_rd.push_back(r);
          st_radr.push_back({ra1, ra0});
          st_exp.push_back({e1, e0});
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_cycle(input string name, input wr_strb_t w, input wr_addr_bus_t wa,
                             input wr_data_bus_t d, input wr_data_bus_t m, input rd_strb_t r,
                             input rd_addr_bus_t ra, input rd_data_bus_t e);
    @(negedge clk);
    check_outputs();
    write  = w;
    wr_adr = wa;
    din    = d;
    bw     = m;
    read   = r;
    rd_adr = ra;
    for (int p = 0; p < num_rd; p++) begin
      if (r[p]) begin
        exp_q[p].push_back(e[p*word_w +: word_w]);
        exp_nm[p].push_back(name);
      end
    end
    for (int i = rd_latency - 1; i > 0; i--) begin
      rd_hist[i] = rd_hist[i-1];
      nm_hist[i] = nm_hist[i-1];
    end
    rd_hist[0] = r;
    nm_hist[0] = name;
  endtask

  task automatic idle_cycle(input string name);
    drive_cycle(name, '0, '0, '0, '0, '0, '0, '0);
  endtask

  // ####################
  // Main sequence
  // ####################
  initial begin
    int    gap;
    string prev;
    read   = '1;
    rd_adr = '0;
    write  = '0;
    wr_adr = '0;
    din    = '0;
    bw     = '0;
    prev   = "";
    for (int i = 0; i < rd_latency; i++) begin
      rd_hist[i] = '0;
      nm_hist[i] = "reset";
    end
    load_stim();
    wd_limit_ns = st_name.size() * (3 + rd_latency + 2) * 20 + 200;
    stim_loaded = 1'b1;

    // Reads requested in reset never reach rd_vld.
    do begin
      @(negedge clk);
      compare_vld("reset", '0, rd_vld);
      read = '0;
    end while (rst);

    foreach (st_name[i]) begin
      // Idle gaps only between tests.
      if (st_name[i] != prev) begin
        gap = {$random(seed)} % 4;
        repeat (gap) idle_cycle("gap");
      end
      prev = st_name[i];
      drive_cycle(st_name[i], st_wr[i], st_wadr[i], st_din[i], st_bw[i],
                  st_rd[i], st_radr[i], st_exp[i]);
    end

    repeat (rd_latency + 1) idle_cycle("drain");

    if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      abort_run("Some reads never returned a read valid.");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  // Watchdog.
  initial begin
    wait (stim_loaded);
    #(wd_limit_ns);
    abort_run("Timeout: the run did not finish in the expected time.");
  end

endmodule

// ==== mem_2r3w_stim.txt ====
# name wr(cba) adr_a adr_b adr_c din_a din_b din_c bw_a bw_b bw_c rd(10) radr0 radr1 exp0 exp1
# wr and rd are binary with the highest port on the left; all other fields are hex.
idle 000 00 00 00 0000 0000 0000 0000 0000 0000 00 00 00 0000 0000
idle 000 00 00 00 0000 0000 0000 0000 0000 0000 00 00 00 0000 0000
idle 000 00 00 00 0000 0000 0000 0000 0000 0000 00 00 00 0000 0000
full_wr 111 10 20 30 1234 2345 3456 7fff 7fff 7fff 00 00 00 0000 0000
full_wr 000 00 00 00 0000 0000 0000 0000 0000 0000 11 10 20 1234 2345
full_wr 000 00 00 00 0000 0000 0000 0000 0000 0000 11 30 10 3456 1234
full_wr 000 00 00 00 0000 0000 0000 0000 0000 0000 11 20 30 2345 3456
mask_wr 111 40 41 42 7fff 0000 5555 7fff 7fff 7fff 00 00 00 0000 0000
mask_wr 111 40 41 42 0000 7fff 2aaa 00ff 7f00 000f 00 00 00 0000 0000
mask_wr 000 00 00 00 0000 0000 0000 0000 0000 0000 11 40 41 7f00 7f00
mask_wr 000 00 00 00 0000 0000 0000 0000 0000 0000 11 42 40 555a 7f00
prio_wr 001 50 00 00 0000 0000 0000 7fff 0000 0000 00 00 00 0000 0000
prio_wr 111 50 50 50 7fff 0000 7fff 00ff 0ff0 0f00 00 00 00 0000 0000
prio_wr 000 00 00 00 0000 0000 0000 0000 0000 0000 11 50 50 0f0f 0f0f
prio_wr 111 51 51 51 1111 2222 3333 7fff 7fff 7fff 00 00 00 0000 0000
prio_wr 000 00 00 00 0000 0000 0000 0000 0000 0000 11 51 50 3333 0f0f
rd_wr_same 001 60 00 00 0aaa 0000 0000 7fff 0000 0000 00 00 00 0000 0000
rd_wr_same 010 00 60 00 0000 0555 0000 0000 7fff 0000 11 60 60 0aaa 0aaa
rd_wr_same 100 00 00 60 0000 0000 7777 0000 0000 7fff 11 60 10 0555 1234
rd_wr_same 000 00 00 00 0000 0000 0000 0000 0000 0000 01 60 00 7777 0000
b2b 111 70 71 72 0101 0202 0303 7fff 7fff 7fff 00 00 00 0000 0000
b2b 111 73 74 75 0404 0505 0606 7fff 7fff 7fff 00 00 00 0000 0000
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 11 70 71 0101 0202
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 11 72 73 0303 0404
b2b 001 76 00 00 4321 0000 0000 7fff 0000 0000 11 74 75 0505 0606
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 11 71 70 0202 0101
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 11 73 72 0404 0303
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 11 75 74 0606 0505
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 11 76 30 4321 3456
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 01 40 00 7f00 0000
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 10 00 42 0000 555a
b2b 000 00 00 00 0000 0000 0000 0000 0000 0000 11 20 41 2345 7f00

// ==== flist.f ====
mem_geom_pkg.sv
mem_port_pkg.sv
mprt_3w2r_sram.sv
algo_2r3w_wrap.sv
mem_2r3w_top.sv
tb_clk_gen.sv
tb_mem_2r3w.sv

// ==== Makefile ====
TOP = tb_mem_2r3w
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
